//--- include/pipe_config.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths are fixed by the RV64 subset, change with care
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef PIPE_CONFIG_SVH
`define PIPE_CONFIG_SVH

// data path and pc width
`define PIPE_XLEN 64
`define PIPE_ILEN 32

// register file geometry
`define PIPE_RAW  5
`define PIPE_NREG 32

`endif

//--- source/pipe_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// field layout follows the base RV32/64 R and I formats
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "pipe_config.svh"

package pipe_pkg;

    // 5 bits wide to match the full core's ALU op field
    typedef enum logic [4:0] {
        ALU_ADD = 5'd0,
        ALU_SUB = 5'd1,
        ALU_AND = 5'd2,
        ALU_OR  = 5'd3,
        ALU_XOR = 5'd4,
        ALU_SLL = 5'd5,
        ALU_SRL = 5'd6
    } alu_op_e;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    typedef struct packed {
        logic [6:0]           funct7;
        logic [`PIPE_RAW-1:0] rs2;
        logic [`PIPE_RAW-1:0] rs1;
        logic [2:0]           funct3;
        logic [`PIPE_RAW-1:0] rd;
        logic [6:0]           opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0]          imm12;
        logic [`PIPE_RAW-1:0] rs1;
        logic [2:0]           funct3;
        logic [`PIPE_RAW-1:0] rd;
        logic [6:0]           opcode;
    } i_type_t;

    // one instruction word, two views
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } instr_u;

endpackage

//--- source/pipe_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// flush beats enable; payload bits keep no reset value
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "pipe_config.svh"

module if_id_reg (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    input  logic                  enable_i,
    input  logic                  valid_i,
    input  logic [`PIPE_XLEN-1:0] pc_i,
    input  logic [`PIPE_ILEN-1:0] instr_i,
    output logic                  valid_o,
    output logic [`PIPE_XLEN-1:0] pc_o,
    output logic [`PIPE_ILEN-1:0] instr_o
);
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else if (flush_i) begin
            valid_o <= 1'b0;
        end else if (enable_i) begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (enable_i) begin
            pc_o    <= pc_i;
            instr_o <= instr_i;
        end
    end
endmodule

module id_ex_reg (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    input  logic                  enable_i,
    input  logic                  valid_i,
    input  logic [`PIPE_XLEN-1:0] pc_i,
    input  logic [`PIPE_RAW-1:0]  rd_i,
    input  logic [`PIPE_XLEN-1:0] op_a_i,
    input  logic [`PIPE_XLEN-1:0] op_b_i,
    input  logic [`PIPE_XLEN-1:0] imm_i,
    input  logic                  use_imm_i,
    input  pipe_pkg::alu_op_e     alu_op_i,
    input  logic                  wen_i,
    input  logic                  ebreak_i,
    output logic                  valid_o,
    output logic [`PIPE_XLEN-1:0] pc_o,
    output logic [`PIPE_RAW-1:0]  rd_o,
    output logic [`PIPE_XLEN-1:0] op_a_o,
    output logic [`PIPE_XLEN-1:0] op_b_o,
    output logic [`PIPE_XLEN-1:0] imm_o,
    output logic                  use_imm_o,
    output pipe_pkg::alu_op_e     alu_op_o,
    output logic                  wen_o,
    output logic                  ebreak_o
);
    import pipe_pkg::*;

    // valid_i arrives low when decode inserts a bubble
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o   <= 1'b0;
            use_imm_o <= 1'b0;
            alu_op_o  <= ALU_ADD;
            wen_o     <= 1'b0;
            ebreak_o  <= 1'b0;
        end else if (flush_i) begin
            valid_o <= 1'b0;
        end else if (enable_i) begin
            valid_o   <= valid_i;
            use_imm_o <= use_imm_i;
            alu_op_o  <= alu_op_i;
            wen_o     <= wen_i;
            ebreak_o  <= ebreak_i;
        end
    end

    always_ff @(posedge clk) begin
        if (enable_i) begin
            pc_o   <= pc_i;
            rd_o   <= rd_i;
            op_a_o <= op_a_i;
            op_b_o <= op_b_i;
            imm_o  <= imm_i;
        end
    end
endmodule

module ex_mem_reg (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  enable_i,
    input  logic                  valid_i,
    input  logic [`PIPE_XLEN-1:0] pc_i,
    input  logic [`PIPE_RAW-1:0]  rd_i,
    input  logic [`PIPE_XLEN-1:0] result_i,
    input  logic                  wen_i,
    input  logic                  ebreak_i,
    output logic                  valid_o,
    output logic [`PIPE_XLEN-1:0] pc_o,
    output logic [`PIPE_RAW-1:0]  rd_o,
    output logic [`PIPE_XLEN-1:0] result_o,
    output logic                  wen_o,
    output logic                  ebreak_o
);
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o  <= 1'b0;
            wen_o    <= 1'b0;
            ebreak_o <= 1'b0;
        end else if (enable_i) begin
            valid_o  <= valid_i;
            wen_o    <= wen_i;
            ebreak_o <= ebreak_i;
        end
    end

    always_ff @(posedge clk) begin
        if (enable_i) begin
            pc_o     <= pc_i;
            rd_o     <= rd_i;
            result_o <= result_i;
        end
    end
endmodule

module mem_wb_reg (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  enable_i,
    input  logic                  valid_i,
    input  logic [`PIPE_XLEN-1:0] pc_i,
    input  logic [`PIPE_RAW-1:0]  rd_i,
    input  logic [`PIPE_XLEN-1:0] result_i,
    input  logic                  wen_i,
    input  logic                  ebreak_i,
    output logic                  valid_o,
    output logic [`PIPE_XLEN-1:0] pc_o,
    output logic [`PIPE_RAW-1:0]  rd_o,
    output logic [`PIPE_XLEN-1:0] result_o,
    output logic                  wen_o,
    output logic                  ebreak_o
);
    // retiring slot, feeds write-back and commit
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o  <= 1'b0;
            wen_o    <= 1'b0;
            ebreak_o <= 1'b0;
        end else if (enable_i) begin
            valid_o  <= valid_i;
            wen_o    <= wen_i;
            ebreak_o <= ebreak_i;
        end
    end

    always_ff @(posedge clk) begin
        if (enable_i) begin
            pc_o     <= pc_i;
            rd_o     <= rd_i;
            result_o <= result_i;
        end
    end
endmodule

//--- source/inst_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// only OP, OP-IMM subset and EBREAK; rest decode as no-write
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "pipe_config.svh"

module inst_decode (
    input  pipe_pkg::instr_u      instr_i,
    output logic [`PIPE_RAW-1:0]  rs1_o,
    output logic [`PIPE_RAW-1:0]  rs2_o,
    output logic                  use_rs1_o,
    output logic                  use_rs2_o,
    output logic [`PIPE_RAW-1:0]  rd_o,
    output logic [`PIPE_XLEN-1:0] imm_o,
    output logic                  use_imm_o,
    output pipe_pkg::alu_op_e     alu_op_o,
    output logic                  wen_o,
    output logic                  ebreak_o
);
    import pipe_pkg::*;

    logic legal;
    logic f7_zero;

    assign f7_zero = (instr_i.r.funct7 == 7'h00);
    assign imm_o   = {{(`PIPE_XLEN-12){instr_i.i.imm12[11]}}, instr_i.i.imm12};
    assign wen_o   = legal && (rd_o != '0);

    always_comb begin
        rs1_o     = instr_i.r.rs1;
        rs2_o     = instr_i.r.rs2;
        rd_o      = instr_i.r.rd;
        use_rs1_o = 1'b0;
        use_rs2_o = 1'b0;
        use_imm_o = 1'b0;
        alu_op_o  = ALU_ADD;
        ebreak_o  = 1'b0;
        legal     = 1'b0;
        case (instr_i.r.opcode)
            OPC_OP: begin
                use_rs1_o = 1'b1;
                use_rs2_o = 1'b1;
                legal     = f7_zero;
                case (instr_i.r.funct3)
                    3'b000: begin
                        // funct7 bit 5 picks SUB
                        legal    = f7_zero || (instr_i.r.funct7 == 7'h20);
                        alu_op_o = f7_zero ? ALU_ADD : ALU_SUB;
                    end
                    3'b001: alu_op_o = ALU_SLL;
                    3'b100: alu_op_o = ALU_XOR;
                    3'b101: alu_op_o = ALU_SRL;
                    3'b110: alu_op_o = ALU_OR;
                    3'b111: alu_op_o = ALU_AND;
                    default: legal = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                use_rs1_o = 1'b1;
                use_imm_o = 1'b1;
                legal     = 1'b1;
                case (instr_i.i.funct3)
                    3'b000: alu_op_o = ALU_ADD;
                    3'b100: alu_op_o = ALU_XOR;
                    3'b110: alu_op_o = ALU_OR;
                    3'b111: alu_op_o = ALU_AND;
                    default: legal = 1'b0;
                endcase
            end
            OPC_SYSTEM: ebreak_o = (instr_i == 32'h0010_0073);
            default: legal = 1'b0;
        endcase
        // unsupported words must not interlock
        if (!legal) begin
            use_rs1_o = 1'b0;
            use_rs2_o = 1'b0;
        end
    end
endmodule

//--- source/reg_file.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// write-first reads; x0 is never stored
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "pipe_config.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic [`PIPE_RAW-1:0]  ra1_i,
    input  logic [`PIPE_RAW-1:0]  ra2_i,
    input  logic                  we_i,
    input  logic [`PIPE_RAW-1:0]  wa_i,
    input  logic [`PIPE_XLEN-1:0] wd_i,
    output logic [`PIPE_XLEN-1:0] rd1_o,
    output logic [`PIPE_XLEN-1:0] rd2_o
);
    logic [`PIPE_XLEN-1:0] regs [`PIPE_NREG];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `PIPE_NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && wa_i != '0) begin
            regs[wa_i] <= wd_i;
        end
    end

    // bypass covers a reader sitting behind write-back
    assign rd1_o = (ra1_i == '0) ? '0 : (we_i && wa_i == ra1_i) ? wd_i : regs[ra1_i];
    assign rd2_o = (ra2_i == '0) ? '0 : (we_i && wa_i == ra2_i) ? wd_i : regs[ra2_i];
endmodule

//--- source/int_alu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// no word (W) variants; shifts use 6 bits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "pipe_config.svh"

module int_alu (
    input  pipe_pkg::alu_op_e     alu_op_i,
    input  logic [`PIPE_XLEN-1:0] op_a_i,
    input  logic [`PIPE_XLEN-1:0] op_b_i,
    input  logic [`PIPE_XLEN-1:0] imm_i,
    input  logic                  use_imm_i,
    output logic [`PIPE_XLEN-1:0] result_o
);
    import pipe_pkg::*;

    logic [`PIPE_XLEN-1:0] src_b;

    assign src_b = use_imm_i ? imm_i : op_b_i;

    always_comb begin
        case (alu_op_i)
            ALU_SUB: result_o = op_a_i - src_b;
            ALU_AND: result_o = op_a_i & src_b;
            ALU_OR:  result_o = op_a_i | src_b;
            ALU_XOR: result_o = op_a_i ^ src_b;
            ALU_SLL: result_o = op_a_i << src_b[5:0];
            ALU_SRL: result_o = op_a_i >> src_b[5:0];
            default: result_o = op_a_i + src_b;
        endcase
    end
endmodule

//--- source/hazard_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// interlock only, no forwarding; halt clears on reset alone
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "pipe_config.svh"

module hazard_ctrl (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 flush_i,
    input  logic                 id_valid_i,
    input  logic [`PIPE_RAW-1:0] rs1_i,
    input  logic [`PIPE_RAW-1:0] rs2_i,
    input  logic                 use_rs1_i,
    input  logic                 use_rs2_i,
    input  logic                 ex_valid_i,
    input  logic [`PIPE_RAW-1:0] ex_rd_i,
    input  logic                 ex_wen_i,
    input  logic                 mem_valid_i,
    input  logic [`PIPE_RAW-1:0] mem_rd_i,
    input  logic                 mem_wen_i,
    input  logic                 wb_valid_i,
    input  logic                 wb_ebreak_i,
    output logic                 if_id_en_o,
    output logic                 id_bubble_o,
    output logic                 front_flush_o,
    output logic                 pipe_en_o,
    output logic                 halt_o
);
    logic ex_wr;
    logic mem_wr;
    logic rs1_hit;
    logic rs2_hit;
    logic interlock;
    logic wb_halt;

    assign ex_wr  = ex_valid_i && ex_wen_i;
    assign mem_wr = mem_valid_i && mem_wen_i;

    // MEM/WB writer is served by the write-first file
    assign rs1_hit = use_rs1_i && ((ex_wr && ex_rd_i == rs1_i) || (mem_wr && mem_rd_i == rs1_i));
    assign rs2_hit = use_rs2_i && ((ex_wr && ex_rd_i == rs2_i) || (mem_wr && mem_rd_i == rs2_i));
    assign interlock = id_valid_i && (rs1_hit || rs2_hit);

    // freeze already in the cycle ebreak retires
    assign wb_halt = wb_valid_i && wb_ebreak_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            halt_o <= 1'b0;
        end else if (wb_halt) begin
            halt_o <= 1'b1;
        end
    end

    assign pipe_en_o     = !(halt_o || wb_halt);
    assign if_id_en_o    = pipe_en_o && !interlock;
    assign id_bubble_o   = interlock;
    assign front_flush_o = flush_i && pipe_en_o;
endmodule

//--- source/pipe_core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetcher must hold its inputs while fetch_stall_o is high
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "pipe_config.svh"

module pipe_core (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  fetch_valid_i,
    input  logic [`PIPE_XLEN-1:0] fetch_pc_i,
    input  logic [`PIPE_ILEN-1:0] fetch_instr_i,
    input  logic                  flush_i,
    output logic                  fetch_stall_o,
    output logic                  commit_valid_o,
    output logic [`PIPE_XLEN-1:0] commit_pc_o,
    output logic [`PIPE_RAW-1:0]  commit_rd_o,
    output logic                  commit_wen_o,
    output logic [`PIPE_XLEN-1:0] commit_wdata_o,
    output logic                  halt_o
);
    import pipe_pkg::*;

    logic                  if_id_en;
    logic                  id_bubble;
    logic                  front_flush;
    logic                  pipe_en;

    logic                  id_valid;
    logic [`PIPE_XLEN-1:0] id_pc;
    logic [`PIPE_ILEN-1:0] id_instr;
    logic [`PIPE_RAW-1:0]  dec_rs1;
    logic [`PIPE_RAW-1:0]  dec_rs2;
    logic                  dec_use_rs1;
    logic                  dec_use_rs2;
    logic [`PIPE_RAW-1:0]  dec_rd;
    logic [`PIPE_XLEN-1:0] dec_imm;
    logic                  dec_use_imm;
    alu_op_e               dec_alu_op;
    logic                  dec_wen;
    logic                  dec_ebreak;
    logic [`PIPE_XLEN-1:0] rf_rd1;
    logic [`PIPE_XLEN-1:0] rf_rd2;

    logic                  ex_valid;
    logic [`PIPE_XLEN-1:0] ex_pc;
    logic [`PIPE_RAW-1:0]  ex_rd;
    logic [`PIPE_XLEN-1:0] ex_op_a;
    logic [`PIPE_XLEN-1:0] ex_op_b;
    logic [`PIPE_XLEN-1:0] ex_imm;
    logic                  ex_use_imm;
    alu_op_e               ex_alu_op;
    logic                  ex_wen;
    logic                  ex_ebreak;
    logic [`PIPE_XLEN-1:0] ex_result;

    logic                  mem_valid;
    logic [`PIPE_XLEN-1:0] mem_pc;
    logic [`PIPE_RAW-1:0]  mem_rd;
    logic [`PIPE_XLEN-1:0] mem_result;
    logic                  mem_wen;
    logic                  mem_ebreak;

    logic                  wb_valid;
    logic                  wb_ebreak;

    if_id_reg i_if_id (
        .clk, .rst_n_i, .flush_i(front_flush), .enable_i(if_id_en),
        .valid_i(fetch_valid_i), .pc_i(fetch_pc_i), .instr_i(fetch_instr_i),
        .valid_o(id_valid), .pc_o(id_pc), .instr_o(id_instr)
    );

    inst_decode i_decode (
        .instr_i(id_instr), .rs1_o(dec_rs1), .rs2_o(dec_rs2),
        .use_rs1_o(dec_use_rs1), .use_rs2_o(dec_use_rs2), .rd_o(dec_rd),
        .imm_o(dec_imm), .use_imm_o(dec_use_imm), .alu_op_o(dec_alu_op),
        .wen_o(dec_wen), .ebreak_o(dec_ebreak)
    );

    // write port is driven from the retiring slot
    reg_file i_rf (
        .clk, .rst_n_i, .ra1_i(dec_rs1), .ra2_i(dec_rs2),
        .we_i(commit_valid_o && commit_wen_o), .wa_i(commit_rd_o), .wd_i(commit_wdata_o),
        .rd1_o(rf_rd1), .rd2_o(rf_rd2)
    );

    id_ex_reg i_id_ex (
        .clk, .rst_n_i, .flush_i(front_flush), .enable_i(pipe_en),
        .valid_i(id_valid && !id_bubble), .pc_i(id_pc), .rd_i(dec_rd),
        .op_a_i(rf_rd1), .op_b_i(rf_rd2), .imm_i(dec_imm), .use_imm_i(dec_use_imm),
        .alu_op_i(dec_alu_op), .wen_i(dec_wen), .ebreak_i(dec_ebreak),
        .valid_o(ex_valid), .pc_o(ex_pc), .rd_o(ex_rd),
        .op_a_o(ex_op_a), .op_b_o(ex_op_b), .imm_o(ex_imm), .use_imm_o(ex_use_imm),
        .alu_op_o(ex_alu_op), .wen_o(ex_wen), .ebreak_o(ex_ebreak)
    );

    int_alu i_alu (
        .alu_op_i(ex_alu_op), .op_a_i(ex_op_a), .op_b_i(ex_op_b),
        .imm_i(ex_imm), .use_imm_i(ex_use_imm), .result_o(ex_result)
    );

    ex_mem_reg i_ex_mem (
        .clk, .rst_n_i, .enable_i(pipe_en), .valid_i(ex_valid), .pc_i(ex_pc),
        .rd_i(ex_rd), .result_i(ex_result), .wen_i(ex_wen), .ebreak_i(ex_ebreak),
        .valid_o(mem_valid), .pc_o(mem_pc), .rd_o(mem_rd),
        .result_o(mem_result), .wen_o(mem_wen), .ebreak_o(mem_ebreak)
    );

    // memory stage is a pass-through in this subset
    mem_wb_reg i_mem_wb (
        .clk, .rst_n_i, .enable_i(pipe_en), .valid_i(mem_valid), .pc_i(mem_pc),
        .rd_i(mem_rd), .result_i(mem_result), .wen_i(mem_wen), .ebreak_i(mem_ebreak),
        .valid_o(wb_valid), .pc_o(commit_pc_o), .rd_o(commit_rd_o),
        .result_o(commit_wdata_o), .wen_o(commit_wen_o), .ebreak_o(wb_ebreak)
    );

    hazard_ctrl i_hazard (
        .clk, .rst_n_i, .flush_i, .id_valid_i(id_valid),
        .rs1_i(dec_rs1), .rs2_i(dec_rs2), .use_rs1_i(dec_use_rs1), .use_rs2_i(dec_use_rs2),
        .ex_valid_i(ex_valid), .ex_rd_i(ex_rd), .ex_wen_i(ex_wen),
        .mem_valid_i(mem_valid), .mem_rd_i(mem_rd), .mem_wen_i(mem_wen),
        .wb_valid_i(wb_valid), .wb_ebreak_i(wb_ebreak),
        .if_id_en_o(if_id_en), .id_bubble_o(id_bubble), .front_flush_o(front_flush),
        .pipe_en_o(pipe_en), .halt_o
    );

    // frozen ebreak slot must not commit twice
    assign commit_valid_o = wb_valid && !halt_o;
    assign fetch_stall_o  = !if_id_en;
endmodule

//--- verification/tb_pipe_core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// program must end in EBREAK; a flush kills its entry and the one before
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "pipe_config.svh"

module tb_pipe_core;
    import pipe_pkg::*;

    localparam int K_ADD = 0;
    localparam int K_SUB = 1;
    localparam int K_AND = 2;
    localparam int K_OR = 3;
    localparam int K_XOR = 4;
    localparam int K_SLL = 5;
    localparam int K_SRL = 6;
    localparam int K_ADDI = 7;
    localparam int K_ANDI = 8;
    localparam int K_ORI = 9;
    localparam int K_XORI = 10;
    localparam int K_EBRK = 11;

    logic                  clk = 1'b0;
    logic                  rst_n_i;
    logic                  fetch_valid_i;
    logic [`PIPE_XLEN-1:0] fetch_pc_i;
    logic [`PIPE_ILEN-1:0] fetch_instr_i;
    logic                  flush_i;
    logic                  fetch_stall_o;
    logic                  commit_valid_o;
    logic [`PIPE_XLEN-1:0] commit_pc_o;
    logic [`PIPE_RAW-1:0]  commit_rd_o;
    logic                  commit_wen_o;
    logic [`PIPE_XLEN-1:0] commit_wdata_o;
    logic                  halt_o;

    // program table
    int          n_prog = 0;
    int          t_kind [32];
    int          t_rd [32];
    int          t_rs1 [32];
    int          t_rs2 [32];
    logic [11:0] t_imm [32];
    bit          t_kill [32];
    string       t_name [32];

    // expected commits in program order
    logic [`PIPE_XLEN-1:0] exp_pc [$];
    int                    exp_rd [$];
    bit                    exp_wen [$];
    logic [`PIPE_XLEN-1:0] exp_data [$];
    string                 exp_name [$];
    int                    acc_edge [$];
    int                    acc_stalls [$];

    logic [15:0] lfsr = 16'd84;
    int          cycle = 0;
    int          stall_edges = 0;
    int          lat_checks = 0;

    pipe_core i_dut (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle       <= cycle + 1;
        stall_edges <= stall_edges + int'(fetch_stall_o);
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [11:0] rand_imm12();
        logic [11:0] v;
        for (int b = 0; b < 12; b++) begin
            lfsr = lfsr_next(lfsr);
            v[b] = lfsr[0];
        end
        return v;
    endfunction

    function automatic logic [31:0] encode(input int k, input int rd, input int rs1,
                                           input int rs2, input logic [11:0] imm);
        logic [4:0] d;
        logic [4:0] s1;
        logic [4:0] s2;
        d  = rd[4:0];
        s1 = rs1[4:0];
        s2 = rs2[4:0];
        case (k)
            K_ADD:  return {7'h00, s2, s1, 3'b000, d, OPC_OP};
            K_SUB:  return {7'h20, s2, s1, 3'b000, d, OPC_OP};
            K_SLL:  return {7'h00, s2, s1, 3'b001, d, OPC_OP};
            K_XOR:  return {7'h00, s2, s1, 3'b100, d, OPC_OP};
            K_SRL:  return {7'h00, s2, s1, 3'b101, d, OPC_OP};
            K_OR:   return {7'h00, s2, s1, 3'b110, d, OPC_OP};
            K_AND:  return {7'h00, s2, s1, 3'b111, d, OPC_OP};
            K_ADDI: return {imm, s1, 3'b000, d, OPC_OP_IMM};
            K_XORI: return {imm, s1, 3'b100, d, OPC_OP_IMM};
            K_ORI:  return {imm, s1, 3'b110, d, OPC_OP_IMM};
            K_ANDI: return {imm, s1, 3'b111, d, OPC_OP_IMM};
            default: return {12'h001, 5'd0, 3'b000, 5'd0, OPC_SYSTEM};
        endcase
    endfunction

    function automatic logic [63:0] expect_result(input int k, input logic [63:0] a,
                                                  input logic [63:0] b, input logic [11:0] imm);
        logic [63:0] sx;
        sx = {{52{imm[11]}}, imm};
        case (k)
            K_ADD:  return a + b;
            K_SUB:  return a - b;
            K_AND:  return a & b;
            K_OR:   return a | b;
            K_XOR:  return a ^ b;
            K_SLL:  return a << b[5:0];
            K_SRL:  return a >> b[5:0];
            K_ADDI: return a + sx;
            K_ANDI: return a & sx;
            K_ORI:  return a | sx;
            K_XORI: return a ^ sx;
            default: return 64'd0;
        endcase
    endfunction

    task automatic add_entry(input string nm, input int k, input int rd, input int rs1,
                             input int rs2, input bit kill);
        t_name[n_prog] = nm;
        t_kind[n_prog] = k;
        t_rd[n_prog]   = (k == K_EBRK) ? 0 : rd;
        t_rs1[n_prog]  = rs1;
        t_rs2[n_prog]  = rs2;
        t_imm[n_prog]  = (k >= K_ADDI && k <= K_XORI) ? rand_imm12() : 12'd0;
        t_kill[n_prog] = kill;
        n_prog++;
    endtask

    task automatic build_program();
        add_entry("addi_x1", K_ADDI, 1, 0, 0, 0);
        add_entry("addi_x2", K_ADDI, 2, 0, 0, 0);
        add_entry("addi_x3", K_ADDI, 3, 0, 0, 0);
        add_entry("addi_x4", K_ADDI, 4, 0, 0, 0);
        add_entry("xori_x5", K_XORI, 5, 0, 0, 0);
        add_entry("ori_x6", K_ORI, 6, 0, 0, 0);
        add_entry("andi_x7", K_ANDI, 7, 1, 0, 0);
        add_entry("add_x8", K_ADD, 8, 1, 2, 0);
        add_entry("sub_x9", K_SUB, 9, 3, 4, 0);
        add_entry("and_x10", K_AND, 10, 1, 3, 0);
        add_entry("or_x11", K_OR, 11, 2, 4, 0);
        add_entry("xor_x12", K_XOR, 12, 1, 4, 0);
        add_entry("sll_x13", K_SLL, 13, 1, 2, 0);
        add_entry("srl_x14", K_SRL, 14, 3, 4, 0);
        add_entry("addi_x0", K_ADDI, 0, 1, 0, 0);
        add_entry("add_x15_zero", K_ADD, 15, 0, 0, 0);
        // dependent chain
        add_entry("addi_x16", K_ADDI, 16, 1, 0, 0);
        add_entry("add_x17_dep", K_ADD, 17, 16, 2, 0);
        add_entry("sub_x18_dep", K_SUB, 18, 17, 16, 0);
        add_entry("xori_x19_dep", K_XORI, 19, 18, 0, 0);
        add_entry("addi_x20_flushed", K_ADDI, 20, 0, 0, 0);
        add_entry("addi_x21_flushed", K_ADDI, 21, 0, 0, 1);
        add_entry("add_x22_after_flush", K_ADD, 22, 20, 1, 0);
        add_entry("ori_x23_dep", K_ORI, 23, 22, 0, 0);
        add_entry("ebreak", K_EBRK, 0, 0, 0, 0);
    endtask

    // register file model, walks the table in program order
    task automatic predict_commits();
        logic [63:0] rf [32];
        logic [63:0] v;
        bit          dead;
        for (int r = 0; r < 32; r++) begin
            rf[r] = 64'd0;
        end
        for (int i = 0; i < n_prog; i++) begin
            dead = t_kill[i] || (i + 1 < n_prog && t_kill[i + 1]);
            if (!dead) begin
                v = expect_result(t_kind[i], rf[t_rs1[i]], rf[t_rs2[i]], t_imm[i]);
                exp_pc.push_back(64'(i * 4));
                exp_rd.push_back(t_rd[i]);
                exp_wen.push_back(t_kind[i] != K_EBRK && t_rd[i] != 0);
                exp_data.push_back(v);
                exp_name.push_back(t_name[i]);
                if (t_kind[i] != K_EBRK && t_rd[i] != 0) begin
                    rf[t_rd[i]] = v;
                end
            end
        end
    endtask

    task automatic report_value(input string nm, input string what, input logic [63:0] exp_v,
                                input logic [63:0] act_v);
        $display("** Error %s %s: expected %h, actual %h", nm, what, exp_v, act_v);
        $display("** FAIL **");
        $fatal(1, "commit mismatch");
    endtask

    task automatic report_plain(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "run aborted");
    endtask

    always @(negedge clk) begin : commit_check
        string nm;
        int    lat;
        int    acc;
        int    snap;
        if (rst_n_i && commit_valid_o) begin
            assert (exp_pc.size() > 0 && acc_edge.size() > 0)
            else report_plain($sformatf("unexpected commit of pc %h", commit_pc_o));
            nm   = exp_name.pop_front();
            acc  = acc_edge.pop_front();
            snap = acc_stalls.pop_front();
            assert (commit_pc_o == exp_pc[0]) else report_value(nm, "pc", exp_pc[0], commit_pc_o);
            assert (commit_rd_o == 5'(exp_rd[0]))
            else report_value(nm, "rd", 64'(exp_rd[0]), 64'(commit_rd_o));
            assert (commit_wen_o == exp_wen[0])
            else report_value(nm, "wen", 64'(exp_wen[0]), 64'(commit_wen_o));
            if (exp_wen[0]) begin
                assert (commit_wdata_o == exp_data[0])
                else report_value(nm, "data", exp_data[0], commit_wdata_o);
            end
            lat = cycle + 1 - acc;
            // no stall edge since acceptance means a clean pass
            if (stall_edges == snap) begin
                lat_checks++;
                assert (lat == 4) else report_value(nm, "latency", 64'd4, 64'(lat));
            end
            void'(exp_pc.pop_front());
            void'(exp_rd.pop_front());
            void'(exp_wen.pop_front());
            void'(exp_data.pop_front());
        end
    end

    task automatic send_entry(input int i);
        int  tries;
        bit  dead;
        tries = 0;
        dead  = t_kill[i] || (i + 1 < n_prog && t_kill[i + 1]);
        fetch_valid_i = 1'b1;
        fetch_pc_i    = 64'(i * 4);
        fetch_instr_i = encode(t_kind[i], t_rd[i], t_rs1[i], t_rs2[i], t_imm[i]);
        while (fetch_stall_o) begin
            @(negedge clk);
            tries++;
            assert (tries < 50) else report_plain($sformatf("fetch stalled too long at %0d", i));
        end
        flush_i = t_kill[i];
        if (!dead) begin
            acc_edge.push_back(cycle + 1);
            acc_stalls.push_back(stall_edges);
        end
        @(negedge clk);
        flush_i = 1'b0;
    endtask

    initial begin
        int tries;
        int prog_stalls;
        rst_n_i       = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_pc_i    = '0;
        fetch_instr_i = '0;
        flush_i       = 1'b0;
        build_program();
        predict_commits();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        @(negedge clk);
        assert (!fetch_stall_o && !commit_valid_o && !halt_o)
        else report_plain("outputs not idle after reset");

        for (int i = 0; i < n_prog; i++) begin
            send_entry(i);
        end
        // ebreak is still in decode here, so only interlocks have stalled so far
        prog_stalls = stall_edges;
        // trailing instruction sits behind the ebreak and must never retire
        fetch_valid_i = 1'b1;
        fetch_pc_i    = 64'(n_prog * 4);
        fetch_instr_i = encode(K_ADDI, 25, 0, 0, 12'h001);

        tries = 0;
        while (!halt_o) begin
            @(negedge clk);
            tries++;
            assert (tries < 100) else report_plain("halt never rose after ebreak");
        end
        for (int w = 0; w < 20; w++) begin
            @(negedge clk);
            assert (halt_o) else report_plain("halt dropped after ebreak");
        end
        assert (prog_stalls > 0) else report_plain("interlock never stalled the fetch");
        assert (lat_checks > 0) else report_plain("no unstalled commit was timed");

        if (exp_pc.size() == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("%0d expected commits never arrived", exp_pc.size());
            $display("** FAIL **");
            $fatal(1, "missing commits");
        end
    end
endmodule

//--- list.f
+incdir+include
source/pipe_pkg.sv
source/pipe_regs.sv
source/inst_decode.sv
source/reg_file.sv
source/int_alu.sv
source/hazard_ctrl.sv
source/pipe_core.sv
verification/tb_pipe_core.sv

//--- Makefile
# Verilator build and run for the pipeline testbench

TOP := tb_pipe_core

.PHONY: all build run lint clean

all: run

build:
	verilator --binary -j 0 -Wno-fatal --top-module $(TOP) -f list.f -Mdir obj_dir

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only -Wall --top-module pipe_core \
		+incdir+include source/pipe_pkg.sv source/pipe_regs.sv source/inst_decode.sv \
		source/reg_file.sv source/int_alu.sv source/hazard_ctrl.sv source/pipe_core.sv

clean:
	rm -rf obj_dir
